// ==== hdl/vunpack_pkg.sv ====
// shared widths and types of the operand unpack pipeline
// imported by every module of the vector register unpack unit

package vunpack_pkg;

    // vector register and read port width
    localparam int unsigned VREG_W = 128;

    // width of one unpacked operand
    localparam int unsigned OP_W = 32;

    // vector register address width
    localparam int unsigned VADDR_W = 5;

    // number of operand lanes, each with its own read port
    localparam int unsigned OP_CNT = 2;

    // control word carried alongside the operands
    localparam int unsigned CTRL_W = 8;

    // scalar operand width
    localparam int unsigned XVAL_W = 32;

    // element width of the current step
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // per operand unpack flags
    typedef struct packed {
        // operand comes from a vector register, otherwise the scalar is broadcast
        logic vreg;
        // elements are half width and get extended to the element width
        logic narrow;
        // sign extension for narrow operands, zero extension otherwise
        logic sigext;
        // only one element is consumed per step
        logic elemwise;
    } unpack_flags_t;

endpackage

// ==== hdl/unpack_stage_ctrl.sv ====
// input handshake and stage 1 register of the unpack pipeline
// holds the step state used for operand extraction while stage 1 is valid

`timescale 1ns/1ps

module unpack_stage_ctrl (
    input  logic                                                        clk_i,
    input  logic                                                        async_rst_ni,

    // input side
    input  logic                                                        in_valid_i,
    output logic                                                        in_ready_o,
    output logic                                                        in_fire_o,
    input  logic                     [vunpack_pkg::CTRL_W-1:0]          in_ctrl_i,
    input  vunpack_pkg::eew_e                                           in_eew_i,
    input  vunpack_pkg::unpack_flags_t [vunpack_pkg::OP_CNT-1:0]        in_flags_i,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::XVAL_W-1:0]     in_xval_i,

    // ready of the following output register
    input  logic                                                        out_ready_i,

    // stage 1 state
    output logic                                                        s1_valid_o,
    output logic                     [vunpack_pkg::CTRL_W-1:0]          s1_ctrl_o,
    output vunpack_pkg::eew_e                                           s1_eew_o,
    output vunpack_pkg::unpack_flags_t [vunpack_pkg::OP_CNT-1:0]        s1_flags_o,
    output logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::XVAL_W-1:0]     s1_xval_o
);

    import vunpack_pkg::*;

    logic                                  s1_valid_q;
    logic          [CTRL_W-1:0]            s1_ctrl_q;
    eew_e                                  s1_eew_q;
    unpack_flags_t [OP_CNT-1:0]            s1_flags_q;
    logic          [OP_CNT-1:0][XVAL_W-1:0] s1_xval_q;

    // stage 1 moves on whenever the output register takes it, and an empty
    // stage 1 always accepts, so bubbles do not hold up the input
    assign in_ready_o = ~s1_valid_q | out_ready_i;
    assign in_fire_o  = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            // drained without refill clears the stage
            s1_valid_q <= in_valid_i;
        end
    end

    // step state, only meaningful while the valid bit is set
    always_ff @(posedge clk_i) begin
        if (in_fire_o) begin
            s1_ctrl_q  <= in_ctrl_i;
            s1_eew_q   <= in_eew_i;
            s1_flags_q <= in_flags_i;
            s1_xval_q  <= in_xval_i;
        end
    end

    assign s1_valid_o = s1_valid_q;
    assign s1_ctrl_o  = s1_ctrl_q;
    assign s1_eew_o   = s1_eew_q;
    assign s1_flags_o = s1_flags_q;
    assign s1_xval_o  = s1_xval_q;

endmodule

// ==== hdl/operand_lane.sv ====
// operand buffer and extraction for one operand lane
// the buffer is loaded or shifted on each accepted step, the operand is
// extracted combinationally from it with the stage 1 width and flags

`timescale 1ns/1ps

module operand_lane (
    input  logic                                 clk_i,

    // buffer update, driven by the step being accepted
    input  logic                                 in_fire_i,
    input  logic                                 load_i,
    input  vunpack_pkg::eew_e                    in_eew_i,
    input  vunpack_pkg::unpack_flags_t           in_flags_i,
    input  logic [vunpack_pkg::VREG_W-1:0]       rd_data_i,

    // extraction, driven by the step held in stage 1
    input  vunpack_pkg::eew_e                    s1_eew_i,
    input  vunpack_pkg::unpack_flags_t           s1_flags_i,
    input  logic [vunpack_pkg::XVAL_W-1:0]       s1_xval_i,

    output logic [vunpack_pkg::OP_W-1:0]         op_data_o
);

    import vunpack_pkg::*;

    logic [VREG_W-1:0] vbuf_q;
    logic [VREG_W-1:0] vbuf_d;
    int unsigned       shift_bits;

    // amount consumed by the accepted step
    always_comb begin
        shift_bits = OP_W;
        if (in_flags_i.elemwise) begin
            // one element of 1, 2 or 4 bytes
            case (in_eew_i)
                EEW_8:   shift_bits = 8;
                EEW_16:  shift_bits = 16;
                default: shift_bits = 32;
            endcase
        end else if (in_flags_i.narrow) begin
            // narrow steps use half an operand of source data
            shift_bits = OP_W / 2;
        end
    end

    // a load replaces the whole buffer, upper bits fill with zeros on shifts
    always_comb begin
        if (load_i) begin
            vbuf_d = rd_data_i;
        end else begin
            vbuf_d = vbuf_q >> shift_bits;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire_i) begin
            vbuf_q <= vbuf_d;
        end
    end

    // operand extraction
    always_comb begin
        // raw low part of the buffer by default
        op_data_o = vbuf_q[OP_W-1:0];

        if (!s1_flags_i.vreg) begin
            // scalar low element repeated across the operand
            case (s1_eew_i)
                EEW_8: begin
                    for (int j = 0; j < OP_W / 8; j++) begin
                        op_data_o[8*j +: 8] = s1_xval_i[7:0];
                    end
                end
                EEW_16: begin
                    for (int j = 0; j < OP_W / 16; j++) begin
                        op_data_o[16*j +: 16] = s1_xval_i[15:0];
                    end
                end
                default: begin
                    for (int j = 0; j < OP_W / 32; j++) begin
                        op_data_o[32*j +: 32] = s1_xval_i[31:0];
                    end
                end
            endcase
        end else if (s1_flags_i.narrow) begin
            // bytes extended to halfwords, or halfwords extended to words;
            // narrow with 8 bit elements has nothing to extend to
            case (s1_eew_i)
                EEW_16: begin
                    for (int j = 0; j < OP_W / 16; j++) begin
                        op_data_o[16*j +: 16] = {
                            {8{s1_flags_i.sigext & vbuf_q[8*j + 7]}},
                            vbuf_q[8*j +: 8]
                        };
                    end
                end
                EEW_32: begin
                    for (int j = 0; j < OP_W / 32; j++) begin
                        op_data_o[32*j +: 32] = {
                            {16{s1_flags_i.sigext & vbuf_q[16*j + 15]}},
                            vbuf_q[16*j +: 16]
                        };
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/unpack_out_reg.sv ====
// final stage register of the unpack pipeline with the output handshake
// payload stays stable while the consumer stalls

`timescale 1ns/1ps

module unpack_out_reg (
    input  logic                                                    clk_i,
    input  logic                                                    async_rst_ni,

    // stage 1 side
    input  logic                                                    s1_valid_i,
    input  logic [vunpack_pkg::CTRL_W-1:0]                          s1_ctrl_i,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::OP_W-1:0]   op_data_i,
    output logic                                                    out_ready_o,

    // output side
    output logic                                                    pipe_out_valid_o,
    input  logic                                                    pipe_out_ready_i,
    output logic [vunpack_pkg::CTRL_W-1:0]                          pipe_out_ctrl_o,
    output logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::OP_W-1:0]   pipe_out_op_data_o
);

    import vunpack_pkg::*;

    logic                         valid_q;
    logic [CTRL_W-1:0]            ctrl_q;
    logic [OP_CNT-1:0][OP_W-1:0]  op_data_q;

    // room for a new item when empty or when the current one leaves
    assign out_ready_o = ~valid_q | pipe_out_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (out_ready_o) begin
            valid_q <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_i && out_ready_o) begin
            ctrl_q    <= s1_ctrl_i;
            op_data_q <= op_data_i;
        end
    end

    assign pipe_out_valid_o   = valid_q;
    assign pipe_out_ctrl_o    = ctrl_q;
    assign pipe_out_op_data_o = op_data_q;

endmodule

// ==== hdl/vreg_unpack.sv ====
// top level of the vector register operand unpack pipeline
// one stage controller, one operand lane per read port, one output register

`timescale 1ns/1ps

module vreg_unpack (
    input  logic                                                        clk_i,
    input  logic                                                        async_rst_ni,

    // pipeline input
    input  logic                                                        pipe_in_valid_i,
    output logic                                                        pipe_in_ready_o,
    input  logic                     [vunpack_pkg::CTRL_W-1:0]          pipe_in_ctrl_i,
    input  vunpack_pkg::eew_e                                           pipe_in_eew_i,
    input  logic                     [vunpack_pkg::OP_CNT-1:0]          pipe_in_op_load_i,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::VADDR_W-1:0]    pipe_in_op_vaddr_i,
    input  vunpack_pkg::unpack_flags_t [vunpack_pkg::OP_CNT-1:0]        pipe_in_op_flags_i,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::XVAL_W-1:0]     pipe_in_op_xval_i,

    // register file read ports, one per lane, answered in the same cycle
    output logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::VADDR_W-1:0]    vreg_rd_addr_o,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::VREG_W-1:0]     vreg_rd_data_i,

    // pipeline output
    output logic                                                        pipe_out_valid_o,
    input  logic                                                        pipe_out_ready_i,
    output logic                     [vunpack_pkg::CTRL_W-1:0]          pipe_out_ctrl_o,
    output logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::OP_W-1:0]       pipe_out_op_data_o
);

    import vunpack_pkg::*;

    logic                                   in_fire;
    logic                                   out_ready;
    logic                                   s1_valid;
    logic          [CTRL_W-1:0]             s1_ctrl;
    eew_e                                   s1_eew;
    unpack_flags_t [OP_CNT-1:0]             s1_flags;
    logic          [OP_CNT-1:0][XVAL_W-1:0] s1_xval;
    logic          [OP_CNT-1:0][OP_W-1:0]   op_data;

    // addresses go straight to the register file
    assign vreg_rd_addr_o = pipe_in_op_vaddr_i;

    unpack_stage_ctrl u_stage_ctrl (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (pipe_in_valid_i),
        .in_ready_o   (pipe_in_ready_o),
        .in_fire_o    (in_fire),
        .in_ctrl_i    (pipe_in_ctrl_i),
        .in_eew_i     (pipe_in_eew_i),
        .in_flags_i   (pipe_in_op_flags_i),
        .in_xval_i    (pipe_in_op_xval_i),
        .out_ready_i  (out_ready),
        .s1_valid_o   (s1_valid),
        .s1_ctrl_o    (s1_ctrl),
        .s1_eew_o     (s1_eew),
        .s1_flags_o   (s1_flags),
        .s1_xval_o    (s1_xval)
    );

    for (genvar i = 0; i < OP_CNT; i++) begin : g_lane
        operand_lane u_lane (
            .clk_i      (clk_i),
            .in_fire_i  (in_fire),
            .load_i     (pipe_in_op_load_i[i]),
            .in_eew_i   (pipe_in_eew_i),
            .in_flags_i (pipe_in_op_flags_i[i]),
            .rd_data_i  (vreg_rd_data_i[i]),
            .s1_eew_i   (s1_eew),
            .s1_flags_i (s1_flags[i]),
            .s1_xval_i  (s1_xval[i]),
            .op_data_o  (op_data[i])
        );
    end

    unpack_out_reg u_out_reg (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .s1_valid_i         (s1_valid),
        .s1_ctrl_i          (s1_ctrl),
        .op_data_i          (op_data),
        .out_ready_o        (out_ready),
        .pipe_out_valid_o   (pipe_out_valid_o),
        .pipe_out_ready_i   (pipe_out_ready_i),
        .pipe_out_ctrl_o    (pipe_out_ctrl_o),
        .pipe_out_op_data_o (pipe_out_op_data_o)
    );

endmodule

// ==== tests/vreg_unpack_chk.sv ====
// protocol and reset checks on the vreg_unpack ports
// bound into the DUT by the testbench which reads fail_cnt at the end

`timescale 1ns/1ps

module vreg_unpack_chk (
    input  logic                                                    clk_i,
    input  logic                                                    async_rst_ni,
    input  logic                                                    pipe_in_valid_i,
    input  logic                                                    pipe_in_ready_o,
    input  logic                                                    pipe_out_valid_o,
    input  logic                                                    pipe_out_ready_i,
    input  logic [vunpack_pkg::CTRL_W-1:0]                          pipe_out_ctrl_o,
    input  logic [vunpack_pkg::OP_CNT-1:0][vunpack_pkg::OP_W-1:0]   pipe_out_op_data_o
);

    import vunpack_pkg::*;

    int unsigned fail_cnt = 0;
    int unsigned occupancy;
    logic        in_xfer;
    logic        out_xfer;

    assign in_xfer  = pipe_in_valid_i & pipe_in_ready_o;
    assign out_xfer = pipe_out_valid_o & pipe_out_ready_i;

    // items accepted at the input and not yet handed out
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            occupancy <= 0;
        end else if (in_xfer && !out_xfer) begin
            occupancy <= occupancy + 1;
        end else if (out_xfer && !in_xfer) begin
            occupancy <= occupancy - 1;
        end
    end

    // first cycle out of reset has nothing to offer
    assert property (@(posedge clk_i) $rose(async_rst_ni) |-> !pipe_out_valid_o)
    else begin
        fail_cnt++;
        $error("output valid in the cycle after reset");
    end

    // a stalled output keeps valid and payload
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (pipe_out_valid_o && !pipe_out_ready_i)
        |=> (pipe_out_valid_o && $stable(pipe_out_ctrl_o) && $stable(pipe_out_op_data_o)))
    else begin
        fail_cnt++;
        $error("output changed while stalled");
    end

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (occupancy == 0) |-> pipe_in_ready_o)
    else begin
        fail_cnt++;
        $error("input not ready with an empty pipeline");
    end

endmodule

// ==== tests/tb_vreg_unpack.sv ====
// testbench for the vector register operand unpack pipeline
// drives load, shift, narrow and scalar steps through vreg_unpack and checks
// every output transfer against a queue of expected items with assertions

`timescale 1ns/1ps

module tb_vreg_unpack;

    import vunpack_pkg::*;

    localparam int unsigned STEPS = 78;
    localparam int unsigned EXP_W = CTRL_W + OP_CNT * OP_W;

    logic                                clk_i = 1'b0;
    logic                                async_rst_ni;
    logic                                pipe_in_valid_i;
    logic                                pipe_in_ready_o;
    logic [CTRL_W-1:0]                   pipe_in_ctrl_i;
    eew_e                                pipe_in_eew_i;
    logic [OP_CNT-1:0]                   pipe_in_op_load_i;
    logic [OP_CNT-1:0][VADDR_W-1:0]      pipe_in_op_vaddr_i;
    unpack_flags_t [OP_CNT-1:0]          pipe_in_op_flags_i;
    logic [OP_CNT-1:0][XVAL_W-1:0]       pipe_in_op_xval_i;
    logic [OP_CNT-1:0][VADDR_W-1:0]      vreg_rd_addr_o;
    logic [OP_CNT-1:0][VREG_W-1:0]       vreg_rd_data_i;
    logic                                pipe_out_valid_o;
    logic                                pipe_out_ready_i;
    logic [CTRL_W-1:0]                   pipe_out_ctrl_o;
    logic [OP_CNT-1:0][OP_W-1:0]         pipe_out_op_data_o;

    // expected items in input order with the head copied out for the assertions
    logic [EXP_W-1:0]   exp_q[$];
    logic [EXP_W-1:0]   exp_head;
    logic               exp_valid;
    int unsigned        errors;
    logic               random_ready;
    logic               random_gaps;
    logic               stall_out;
    logic [CTRL_W-1:0]  ctrl_cnt;

    // per lane model of the buffer as source register and bits consumed
    logic [VADDR_W-1:0] base_reg[OP_CNT];
    int unsigned        base_off[OP_CNT];

    vreg_unpack uut (.*);

    bind vreg_unpack vreg_unpack_chk u_chk (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .pipe_in_valid_i    (pipe_in_valid_i),
        .pipe_in_ready_o    (pipe_in_ready_o),
        .pipe_out_valid_o   (pipe_out_valid_o),
        .pipe_out_ready_i   (pipe_out_ready_i),
        .pipe_out_ctrl_o    (pipe_out_ctrl_o),
        .pipe_out_op_data_o (pipe_out_op_data_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [7:0] reg_byte(input logic [VADDR_W-1:0] r, input int unsigned k);
        int unsigned v;
        v = (32'(r) * 16 + k) % 256;
        return v[7:0];
    endfunction

    // bits [off +: OP_W] of register r with zeros above the register
    function automatic logic [OP_W-1:0] reg_slice(input logic [VADDR_W-1:0] r,
                                                  input int unsigned off);
        logic [OP_W-1:0] w;
        logic [7:0]      byt;
        int unsigned     b;
        w = '0;
        for (int unsigned n = 0; n < OP_W; n++) begin
            b = off + n;
            if (b < VREG_W) begin
                byt  = reg_byte(r, b / 8);
                w[n] = byt[b[2:0]];
            end
        end
        return w;
    endfunction

    function automatic int unsigned step_bits(input eew_e eew, input unpack_flags_t f);
        if (f.elemwise) begin
            return (eew == EEW_8) ? 8 : ((eew == EEW_16) ? 16 : 32);
        end
        return f.narrow ? OP_W / 2 : OP_W;
    endfunction

    function automatic logic [OP_W-1:0] expect_operand(input logic [OP_W-1:0] raw,
                                                       input eew_e eew, input unpack_flags_t f,
                                                       input logic [XVAL_W-1:0] x);
        logic [OP_W-1:0] o;
        o = raw;
        if (!f.vreg) begin
            case (eew)
                EEW_8:   o = {4{x[7:0]}};
                EEW_16:  o = {2{x[15:0]}};
                default: o = x;
            endcase
        end else if (f.narrow && eew == EEW_16) begin
            o = {{8{f.sigext & raw[15]}}, raw[15:8], {8{f.sigext & raw[7]}}, raw[7:0]};
        end else if (f.narrow && eew == EEW_32) begin
            o = {{16{f.sigext & raw[15]}}, raw[15:0]};
        end
        return o;
    endfunction

    function automatic eew_e pick_eew(input int unsigned v);
        case (v % 3)
            0:       return EEW_8;
            1:       return EEW_16;
            default: return EEW_32;
        endcase
    endfunction

    // register file answers in the same cycle
    always_comb begin
        for (int i = 0; i < OP_CNT; i++) begin
            for (int unsigned k = 0; k < VREG_W / 8; k++) begin
                vreg_rd_data_i[i][8*k +: 8] = reg_byte(vreg_rd_addr_o[i], k);
            end
        end
    end

    always @(posedge clk_i) begin
        #1;
        pipe_out_ready_i = stall_out ? 1'b0
                         : (random_ready ? (($urandom % 2) == 0) : 1'b1);
    end

    // drop the head on each output transfer and refresh the copy for the assertions
    always @(posedge clk_i) begin
        if (pipe_out_valid_o && pipe_out_ready_i && exp_q.size() != 0) begin
            exp_q.delete(0);
        end
        exp_valid = exp_q.size() != 0;
        if (exp_valid) begin
            exp_head = exp_q[0];
        end
    end

    task automatic send_step(input eew_e eew, input logic load, input unpack_flags_t f,
                             input logic [VADDR_W-1:0] a0, input logic [VADDR_W-1:0] a1,
                             input logic [XVAL_W-1:0] x0, input logic [XVAL_W-1:0] x1);
        logic [OP_CNT-1:0][OP_W-1:0] ops;
        pipe_in_valid_i       = 1'b1;
        pipe_in_ctrl_i        = ctrl_cnt;
        pipe_in_eew_i         = eew;
        pipe_in_op_load_i     = {load, load};
        pipe_in_op_vaddr_i    = {a1, a0};
        pipe_in_op_flags_i    = {f, f};
        pipe_in_op_xval_i     = {x1, x0};
        @(posedge clk_i);
        while (!pipe_in_ready_o) begin
            @(posedge clk_i);
        end
        for (int i = 0; i < OP_CNT; i++) begin
            if (load) begin
                base_reg[i] = pipe_in_op_vaddr_i[i];
                base_off[i] = 0;
            end else begin
                base_off[i] = base_off[i] + step_bits(eew, f);
            end
            ops[i] = expect_operand(reg_slice(base_reg[i], base_off[i]), eew, f,
                                    pipe_in_op_xval_i[i]);
        end
        exp_q.push_back({ctrl_cnt, ops});
        ctrl_cnt = ctrl_cnt + 8'd1;
        #1;
        pipe_in_valid_i = 1'b0;
        if (random_gaps) begin
            repeat ($urandom % 3) @(posedge clk_i);
            #1;
        end
    endtask

    task automatic run_block(input eew_e eew, input unpack_flags_t f, input int n,
                             input logic [VADDR_W-1:0] a0, input logic [VADDR_W-1:0] a1);
        for (int s = 0; s < n; s++) begin
            send_step(eew, s == 0, f, a0, a1, $urandom, $urandom);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    genvar g;
    for (g = 0; g < OP_CNT; g++) begin : g_op_check
        assert property (@(posedge clk_i) disable iff (!async_rst_ni)
            (pipe_out_valid_o && pipe_out_ready_i && exp_valid)
            |-> pipe_out_op_data_o[g] == exp_head[g*OP_W +: OP_W])
        else begin
            errors++;
            $display("ERROR %0t pipe_out_op_data_o[%0d] expected %h actual %h", $time, g,
                     $sampled(exp_head[g*OP_W +: OP_W]), $sampled(pipe_out_op_data_o[g]));
        end
    end

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (pipe_out_valid_o && pipe_out_ready_i && exp_valid)
        |-> pipe_out_ctrl_o == exp_head[EXP_W-1 -: CTRL_W])
    else begin
        errors++;
        $display("ERROR %0t pipe_out_ctrl_o expected %h actual %h", $time,
                 $sampled(exp_head[EXP_W-1 -: CTRL_W]), $sampled(pipe_out_ctrl_o));
    end

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (pipe_out_valid_o && pipe_out_ready_i) |-> exp_valid)
    else begin
        errors++;
        $display("output transfer at %0t with no item sent", $time);
    end

    initial begin
        #((STEPS * 4 * 50 + 2000) * 1ns);
        $display("watchdog expired at %0t with %0d items outstanding", $time, exp_q.size());
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h6a7c));
        errors             = 0;
        exp_valid          = 1'b0;
        exp_head           = '0;
        random_ready       = 1'b0;
        random_gaps        = 1'b0;
        stall_out          = 1'b0;
        ctrl_cnt           = '0;
        async_rst_ni       = 1'b0;
        pipe_in_valid_i    = 1'b0;
        pipe_in_ctrl_i     = '0;
        pipe_in_eew_i      = EEW_8;
        pipe_in_op_load_i  = '0;
        pipe_in_op_vaddr_i = '0;
        pipe_in_op_flags_i = '0;
        pipe_in_op_xval_i  = '0;
        pipe_out_ready_i   = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;

        // full width words, then one element per step for each width
        run_block(EEW_32, 4'b1000, 4, 5'd3, 5'd20);
        run_block(EEW_8, 4'b1001, 4, 5'd5, 5'd25);
        run_block(EEW_16, 4'b1001, 4, 5'd6, 5'd26);
        run_block(EEW_32, 4'b1001, 4, 5'd7, 5'd27);

        // narrow steps on registers whose bytes have the top bit set
        run_block(EEW_16, 4'b1100, 4, 5'd8, 5'd9);
        run_block(EEW_16, 4'b1110, 4, 5'd10, 5'd11);
        run_block(EEW_32, 4'b1100, 4, 5'd12, 5'd13);
        run_block(EEW_32, 4'b1110, 4, 5'd14, 5'd15);

        // scalar broadcast
        run_block(EEW_8, 4'b0000, 1, 5'd0, 5'd1);
        run_block(EEW_16, 4'b0000, 1, 5'd0, 5'd1);
        run_block(EEW_32, 4'b0000, 1, 5'd0, 5'd1);

        // random back-pressure and idle gaps
        random_ready = 1'b1;
        random_gaps  = 1'b1;
        for (int s = 0; s < 40; s++) begin
            send_step(pick_eew($urandom), (s % 4) == 0, unpack_flags_t'({1'b1, 3'($urandom)}),
                      5'($urandom), 5'($urandom), $urandom, $urandom);
        end
        random_ready = 1'b0;
        random_gaps  = 1'b0;
        drain();

        // stalled output and full stage 1 when reset hits
        stall_out = 1'b1;
        run_block(EEW_32, 4'b1000, 2, 5'd4, 5'd21);
        async_rst_ni = 1'b0;
        exp_q.delete();
        repeat (2) @(posedge clk_i);
        #1;
        stall_out    = 1'b0;
        async_rst_ni = 1'b1;

        // first item after reset
        run_block(EEW_16, 4'b1100, 1, 5'd9, 5'd30);
        drain();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected items never left the pipeline", exp_q.size());
        end
        $display("errors: %0d  checker failures: %0d", errors, uut.u_chk.fail_cnt);
        if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/vunpack_pkg.sv
hdl/unpack_stage_ctrl.sv
hdl/operand_lane.sv
hdl/unpack_out_reg.sv
hdl/vreg_unpack.sv
tests/vreg_unpack_chk.sv
tests/tb_vreg_unpack.sv

// ==== Makefile ====
# Verilator build and run of the vreg_unpack testbench

TOP = tb_vreg_unpack

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
